// File: common/rv64_pkg.sv
package rv64_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int PC_W       = 40;  // physical fetch address
    localparam int BUS_ADDR_W = 39;  // Sv39-sized data bus
    localparam int REG_ADDR_W = 5;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_IMM_W  = 7'b0011011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_REG_W  = 7'b0111011;

    // funct3 branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load/store size as sent on bus_ls_type
    localparam logic [2:0] LS_B  = 3'b000;
    localparam logic [2:0] LS_H  = 3'b001;
    localparam logic [2:0] LS_W  = 3'b010;
    localparam logic [2:0] LS_D  = 3'b011;
    localparam logic [2:0] LS_BU = 3'b100;
    localparam logic [2:0] LS_HU = 3'b101;
    localparam logic [2:0] LS_WU = 3'b110;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
        ALU_PASS_B,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // branch compares
    } alu_op_e;

    // one instruction word in six layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv64_pkg::*; #(
    parameter logic [PC_W-1:0] RAM_BASE = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [ILEN-1:0] instruction_i,  // comb imem data at pc_o
    input  logic            redirect_i,
    input  logic [PC_W-1:0] redirect_pc_i,
    input  logic            stall_i,
    output logic [PC_W-1:0] pc_o,
    output instr_u          ir_o,
    output logic [PC_W-1:0] ir_pc_o,
    output logic            ir_valid_o
);

    // pc and valid flag
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_o       <= RAM_BASE;
            ir_valid_o <= 1'b0;  // first cycle is a bubble
        end else if (stall_i) begin
            pc_o       <= pc_o;  // load/store still on the bus
            ir_valid_o <= ir_valid_o;
        end else if (redirect_i) begin
            pc_o       <= redirect_pc_i;
            ir_valid_o <= 1'b0;  // kill the wrongly fetched word
        end else begin
            pc_o       <= pc_o + PC_W'(4);
            ir_valid_o <= 1'b1;
        end
    end

    // instruction register captured with its own address
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ir_o    <= instruction_i;
            ir_pc_o <= pc_o;
        end
    end

endmodule

// File: hw/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import rv64_pkg::*; (
    input  instr_u                ir_i,
    input  logic [PC_W-1:0]       ir_pc_i,
    input  logic                  ir_valid_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output alu_op_e               alu_op_o,
    output logic [XLEN-1:0]       op_a_o,
    output logic [XLEN-1:0]       op_b_o,
    output logic [XLEN-1:0]       store_data_o,
    output logic                  is_load_o,
    output logic                  is_store_o,
    output logic                  is_branch_o,
    output logic                  is_jump_o,
    output logic [2:0]            ls_type_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic                  rd_we_o,
    output logic [XLEN-1:0]       link_o,
    output logic [PC_W-1:0]       target_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;  // funct7[5] picks sub and sra
    logic            writes_rd;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [XLEN-1:0] jalr_sum;

    assign opcode = ir_i.r.opcode;
    assign funct3 = ir_i.r.funct3;
    assign alt    = ir_i.r.funct7[5];

    // immediates through the format views
    assign imm_i = {{52{ir_i.i.imm[11]}}, ir_i.i.imm};
    assign imm_s = {{52{ir_i.s.imm_hi[6]}}, ir_i.s.imm_hi, ir_i.s.imm_lo};
    assign imm_b = {{51{ir_i.b.imm_12}}, ir_i.b.imm_12, ir_i.b.imm_11,
                    ir_i.b.imm_10_5, ir_i.b.imm_4_1, 1'b0};
    assign imm_u = {{32{ir_i.u.imm[19]}}, ir_i.u.imm, 12'b0};
    assign imm_j = {{43{ir_i.j.imm_20}}, ir_i.j.imm_20, ir_i.j.imm_19_12,
                    ir_i.j.imm_11, ir_i.j.imm_10_1, 1'b0};

    assign rs1_addr_o   = ir_i.r.rs1;
    assign rs2_addr_o   = ir_i.r.rs2;
    assign rd_addr_o    = ir_i.r.rd;
    assign ls_type_o    = funct3;
    assign store_data_o = rs2_data_i;  // sized later in the lsu

    assign is_load_o   = ir_valid_i && opcode == OP_LOAD;
    assign is_store_o  = ir_valid_i && opcode == OP_STORE;
    assign is_branch_o = ir_valid_i && opcode == OP_BRANCH;
    assign is_jump_o   = ir_valid_i && (opcode == OP_JAL || opcode == OP_JALR);
    assign rd_we_o     = ir_valid_i && writes_rd;

    assign link_o   = XLEN'(ir_pc_i + PC_W'(4));
    assign jalr_sum = rs1_data_i + imm_i;

    // jump/branch target
    always_comb begin
        if (opcode == OP_JALR)
            target_o = {jalr_sum[PC_W-1:1], 1'b0};
        else if (opcode == OP_JAL)
            target_o = ir_pc_i + imm_j[PC_W-1:0];
        else
            target_o = ir_pc_i + imm_b[PC_W-1:0];
    end

    // alu control and operands
    always_comb begin
        alu_op_o  = ALU_ADD;
        op_a_o    = rs1_data_i;
        op_b_o    = rs2_data_i;
        writes_rd = 1'b0;
        case (opcode)
            OP_LUI: begin
                alu_op_o  = ALU_PASS_B;
                op_b_o    = imm_u;
                writes_rd = 1'b1;
            end
            OP_AUIPC: begin
                op_a_o    = XLEN'(ir_pc_i);
                op_b_o    = imm_u;
                writes_rd = 1'b1;
            end
            OP_JAL, OP_JALR: writes_rd = 1'b1;  // alu passes the link
            OP_LOAD: begin
                op_b_o    = imm_i;  // base + offset
                writes_rd = 1'b1;
            end
            OP_STORE: op_b_o = imm_s;
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ:  alu_op_o = ALU_EQ;
                    F3_BNE:  alu_op_o = ALU_NE;
                    F3_BLT:  alu_op_o = ALU_LT;
                    F3_BGE:  alu_op_o = ALU_GE;
                    F3_BLTU: alu_op_o = ALU_LTU;
                    default: alu_op_o = ALU_GEU;
                endcase
            end
            OP_IMM, OP_IMM_W, OP_REG, OP_REG_W: begin
                writes_rd = 1'b1;
                if (opcode == OP_IMM || opcode == OP_IMM_W)
                    op_b_o = imm_i;  // shamt sits in the low bits
                case (funct3)
                    3'b000:  alu_op_o = (alt && (opcode == OP_REG || opcode == OP_REG_W))
                                        ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op_o = ALU_SLL;
                    3'b010:  alu_op_o = ALU_SLT;
                    3'b011:  alu_op_o = ALU_SLTU;
                    3'b100:  alu_op_o = ALU_XOR;
                    3'b101:  alu_op_o = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op_o = ALU_OR;
                    default: alu_op_o = ALU_AND;
                endcase
                // 32-bit word forms
                if (opcode == OP_IMM_W || opcode == OP_REG_W) begin
                    case (alu_op_o)
                        ALU_SUB: alu_op_o = ALU_SUBW;
                        ALU_SLL: alu_op_o = ALU_SLLW;
                        ALU_SRL: alu_op_o = ALU_SRLW;
                        ALU_SRA: alu_op_o = ALU_SRAW;
                        default: alu_op_o = ALU_ADDW;
                    endcase
                end
            end
            default: writes_rd = 1'b0;  // unknown opcode runs as a nop
        endcase
    end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv64_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i
);

    logic [XLEN-1:0] regs [0:31];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;  // x0 never written
        end
    end

    // async read with x0 hardwired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: exec/exec_alu.sv
`timescale 1ns/1ps

module exec_alu import rv64_pkg::*; (
    input  alu_op_e         alu_op_i,
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  logic            is_branch_i,
    input  logic            is_jump_i,
    input  logic [PC_W-1:0] target_i,
    input  logic [XLEN-1:0] link_i,
    output logic [XLEN-1:0] result_o,
    output logic            redirect_o,
    output logic [PC_W-1:0] redirect_pc_o
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [31:0]     word;     // low half of a word op
    logic            is_word;
    logic            eq, lt_s, lt_u;
    logic            taken;    // branch compare holds

    assign sum  = op_a_i + op_b_i;
    assign diff = op_a_i - op_b_i;
    assign eq   = op_a_i == op_b_i;
    assign lt_s = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u = op_a_i < op_b_i;

    always_comb begin
        result_o = '0;
        word     = '0;
        is_word  = 1'b0;
        taken    = 1'b0;
        case (alu_op_i)
            ALU_ADD:    result_o = sum;
            ALU_SUB:    result_o = diff;
            ALU_XOR:    result_o = op_a_i ^ op_b_i;
            ALU_OR:     result_o = op_a_i | op_b_i;
            ALU_AND:    result_o = op_a_i & op_b_i;
            ALU_SLL:    result_o = op_a_i << op_b_i[5:0];
            ALU_SRL:    result_o = op_a_i >> op_b_i[5:0];
            ALU_SRA:    result_o = $signed(op_a_i) >>> op_b_i[5:0];
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_PASS_B: result_o = op_b_i;  // lui
            ALU_ADDW: begin
                is_word = 1'b1;
                word    = sum[31:0];
            end
            ALU_SUBW: begin
                is_word = 1'b1;
                word    = diff[31:0];
            end
            ALU_SLLW: begin
                is_word = 1'b1;
                word    = op_a_i[31:0] << op_b_i[4:0];
            end
            ALU_SRLW: begin
                is_word = 1'b1;
                word    = op_a_i[31:0] >> op_b_i[4:0];
            end
            ALU_SRAW: begin
                is_word = 1'b1;
                word    = $signed(op_a_i[31:0]) >>> op_b_i[4:0];
            end
            ALU_EQ:  taken = eq;
            ALU_NE:  taken = !eq;
            ALU_LT:  taken = lt_s;
            ALU_GE:  taken = !lt_s;
            ALU_LTU: taken = lt_u;
            default: taken = !lt_u;  // geu
        endcase
        if (is_word)
            result_o = {{32{word[31]}}, word};  // sign-extend word results
        if (is_jump_i)
            result_o = link_i;  // jal/jalr write pc+4
    end

    assign redirect_o    = is_jump_i || (is_branch_i && taken);
    assign redirect_pc_o = target_i;

endmodule

// File: exec/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import rv64_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  is_load_i,
    input  logic                  is_store_i,
    input  logic [2:0]            ls_type_i,
    input  logic [XLEN-1:0]       addr_i,
    input  logic [XLEN-1:0]       store_data_i,
    input  logic [XLEN-1:0]       alu_result_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  rd_we_i,
    input  logic                  bus_read_done_i,
    input  logic                  bus_write_done_i,
    input  logic [XLEN-1:0]       bus_read_data_i,
    output logic [BUS_ADDR_W-1:0] bus_address_o,
    output logic [XLEN-1:0]       bus_write_data_o,
    output logic                  bus_write_enable_o,
    output logic                  bus_read_enable_o,
    output logic [2:0]            bus_ls_type_o,
    output logic                  stall_o,
    output logic                  rd_we_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       rd_data_o
);

    logic            wait_q;  // high while waiting for done
    logic            mem_op;
    logic            done;
    logic [XLEN-1:0] load_ext;

    assign mem_op = is_load_i || is_store_i;
    assign done   = wait_q && (is_load_i ? bus_read_done_i : bus_write_done_i);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            wait_q <= 1'b0;
        else if (done)
            wait_q <= 1'b0;
        else if (mem_op)
            wait_q <= 1'b1;  // enable went out this cycle
    end

    // single-cycle enable in the first held cycle
    assign bus_read_enable_o  = !wait_q && is_load_i;
    assign bus_write_enable_o = !wait_q && is_store_i;
    assign bus_address_o      = addr_i[BUS_ADDR_W-1:0];
    assign bus_ls_type_o      = ls_type_i;
    assign stall_o            = mem_op && !done;  // released in the done cycle

    // store data trimmed to its size
    always_comb begin
        case (ls_type_i[1:0])
            2'b00:   bus_write_data_o = {56'b0, store_data_i[7:0]};
            2'b01:   bus_write_data_o = {48'b0, store_data_i[15:0]};
            2'b10:   bus_write_data_o = {32'b0, store_data_i[31:0]};
            default: bus_write_data_o = store_data_i;
        endcase
    end

    // load extension by size and sign
    always_comb begin
        case (ls_type_i)
            LS_B:    load_ext = {{56{bus_read_data_i[7]}}, bus_read_data_i[7:0]};
            LS_H:    load_ext = {{48{bus_read_data_i[15]}}, bus_read_data_i[15:0]};
            LS_W:    load_ext = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]};
            LS_BU:   load_ext = {56'b0, bus_read_data_i[7:0]};
            LS_HU:   load_ext = {48'b0, bus_read_data_i[15:0]};
            LS_WU:   load_ext = {32'b0, bus_read_data_i[31:0]};
            default: load_ext = bus_read_data_i;  // ld
        endcase
    end

    // write-back with loads only on done
    assign rd_we_o   = rd_we_i && (!is_load_i || done);
    assign rd_addr_o = rd_addr_i;
    assign rd_data_o = is_load_i ? load_ext : alu_result_i;

endmodule

// File: hw/rv64_core.sv
`timescale 1ns/1ps

module rv64_core import rv64_pkg::*; #(
    parameter logic [PC_W-1:0] RAM_BASE = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ILEN-1:0]       instruction_i,
    output logic [PC_W-1:0]       pc_o,
    output logic [BUS_ADDR_W-1:0] bus_address_o,
    output logic [XLEN-1:0]       bus_write_data_o,
    output logic                  bus_write_enable_o,
    output logic                  bus_read_enable_o,
    output logic [2:0]            bus_ls_type_o,
    input  logic                  bus_read_done_i,
    input  logic                  bus_write_done_i,
    input  logic [XLEN-1:0]       bus_read_data_i
);

    instr_u                ir;
    logic [PC_W-1:0]       ir_pc, target, redirect_pc;
    logic                  ir_valid, redirect, stall;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, dec_rd_addr, wb_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data, op_a, op_b, store_data;
    logic [XLEN-1:0]       link, alu_result, wb_data;
    alu_op_e               alu_op;
    logic                  is_load, is_store, is_branch, is_jump;
    logic                  dec_rd_we, wb_we;
    logic [2:0]            ls_type;

    fetch_unit #(.RAM_BASE(RAM_BASE)) u_fetch (
        .clk(clk), .reset(reset),
        .instruction_i(instruction_i),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .stall_i(stall),
        .pc_o(pc_o), .ir_o(ir), .ir_pc_o(ir_pc), .ir_valid_o(ir_valid)
    );

    instr_decode u_decode (
        .ir_i(ir), .ir_pc_i(ir_pc), .ir_valid_i(ir_valid),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .alu_op_o(alu_op), .op_a_o(op_a), .op_b_o(op_b),
        .store_data_o(store_data),
        .is_load_o(is_load), .is_store_o(is_store),
        .is_branch_o(is_branch), .is_jump_o(is_jump),
        .ls_type_o(ls_type),
        .rd_addr_o(dec_rd_addr), .rd_we_o(dec_rd_we),
        .link_o(link), .target_o(target)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(wb_we), .waddr_i(wb_addr), .wdata_i(wb_data)
    );

    exec_alu u_alu (
        .alu_op_i(alu_op), .op_a_i(op_a), .op_b_i(op_b),
        .is_branch_i(is_branch), .is_jump_i(is_jump),
        .target_i(target), .link_i(link),
        .result_o(alu_result),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc)
    );

    load_store_unit u_lsu (
        .clk(clk), .reset(reset),
        .is_load_i(is_load), .is_store_i(is_store), .ls_type_i(ls_type),
        .addr_i(alu_result), .store_data_i(store_data), .alu_result_i(alu_result),
        .rd_addr_i(dec_rd_addr), .rd_we_i(dec_rd_we),
        .bus_read_done_i(bus_read_done_i), .bus_write_done_i(bus_write_done_i),
        .bus_read_data_i(bus_read_data_i),
        .bus_address_o(bus_address_o), .bus_write_data_o(bus_write_data_o),
        .bus_write_enable_o(bus_write_enable_o), .bus_read_enable_o(bus_read_enable_o),
        .bus_ls_type_o(bus_ls_type_o),
        .stall_o(stall),
        .rd_we_o(wb_we), .rd_addr_o(wb_addr), .rd_data_o(wb_data)
    );

endmodule

// File: tb/tb_rv64_core.sv
`timescale 1ns/1ps

module tb_rv64_core import rv64_pkg::*; ();

    localparam logic [PC_W-1:0] RAM_BASE = '0;
    localparam int REC_BASE   = 256;   // first entry of the store records
    localparam int WAIT_LIMIT = 2000;  // cycles allowed for the whole program

    logic                  clk;
    logic                  reset;
    logic [ILEN-1:0]       instruction;
    logic [PC_W-1:0]       pc;
    logic [PC_W-1:0]       pc_off;
    logic [BUS_ADDR_W-1:0] bus_address;
    logic [XLEN-1:0]       bus_write_data;
    logic                  bus_write_enable;
    logic                  bus_read_enable;
    logic [2:0]            bus_ls_type;
    logic                  bus_read_done;
    logic                  bus_write_done;
    logic [XLEN-1:0]       bus_read_data;

    logic [63:0] pats [0:511];  // program words followed by records
    logic [7:0]  dmem [0:511];  // byte wide data memory
    integer      seed;
    int          n_rec, rec_idx, errors, tests_run, tests_failed;
    bit          busy;           // one bus transfer open
    bit          busy_is_write;
    int          delay_left;
    logic [8:0]  busy_addr;

    rv64_core #(.RAM_BASE(RAM_BASE)) u_rv64_core (
        .clk(clk), .reset(reset),
        .instruction_i(instruction), .pc_o(pc),
        .bus_address_o(bus_address), .bus_write_data_o(bus_write_data),
        .bus_write_enable_o(bus_write_enable), .bus_read_enable_o(bus_read_enable),
        .bus_ls_type_o(bus_ls_type),
        .bus_read_done_i(bus_read_done), .bus_write_done_i(bus_write_done),
        .bus_read_data_i(bus_read_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    // combinational instruction memory
    assign pc_off      = pc - RAM_BASE;
    assign instruction = pats[pc_off[9:2]][ILEN-1:0];

    function automatic string name_text(input logic [63:0] bits);
        string s;
        s = "";
        for (int b = 7; b >= 0; b--) begin
            if (bits[b*8 +: 8] != 8'h20)  // drop the space padding
                s = $sformatf("%s%c", s, bits[b*8 +: 8]);
        end
        return s;
    endfunction

    function automatic logic [XLEN-1:0] read_dword(input logic [8:0] a);
        logic [XLEN-1:0] d;
        for (int b = 0; b < 8; b++) begin
            d[b*8 +: 8] = dmem[9'(a + b)];  // little endian
        end
        return d;
    endfunction

    task automatic write_bytes(input logic [8:0] a, input logic [2:0] ls_type,
                               input logic [XLEN-1:0] data);
        int n;
        n = 1 << ls_type[1:0];
        for (int b = 0; b < n; b++) begin
            dmem[9'(a + b)] = data[b*8 +: 8];
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual, inout bit ok);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", what, expected, actual);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        tests_run++;
        if (!ok)
            tests_failed++;
        $display("test %s: %s", name, ok ? "passed" : "failed");
    endtask

    // next expected record against the store on the bus
    task automatic check_store(input logic [BUS_ADDR_W-1:0] addr, input logic [2:0] ls_type,
                               input logic [XLEN-1:0] data);
        int    base;
        string name;
        bit    ok;
        if (rec_idx >= n_rec) begin
            $display("store to %h seen after the last expected record", addr);
            errors++;
        end else begin
            base = REC_BASE + 1 + 4 * rec_idx;
            name = name_text(pats[base + 3]);
            ok   = 1'b1;
            check_value({name, " address"}, pats[base], 64'(addr), ok);
            check_value({name, " size"}, pats[base + 1], 64'(ls_type), ok);
            check_value({name, " data"}, pats[base + 2], data, ok);
            report_test(name, ok);
            rec_idx++;
        end
    endtask

    // data memory answering after 1 to 4 cycles
    always @(posedge clk) begin
        bus_read_done  <= 1'b0;
        bus_write_done <= 1'b0;
        if (!reset) begin
            busy = 1'b0;
        end else if (busy) begin
            if (bus_read_enable || bus_write_enable) begin
                $display("bus enable raised while a transfer was still open");
                errors++;
            end
            if (delay_left > 1) begin
                delay_left = delay_left - 1;
            end else begin
                busy = 1'b0;
                if (busy_is_write) begin
                    bus_write_done <= 1'b1;
                end else begin
                    bus_read_done <= 1'b1;
                    bus_read_data <= read_dword(busy_addr);
                end
            end
        end else if (bus_read_enable || bus_write_enable) begin
            busy          = 1'b1;
            busy_is_write = bus_write_enable;
            busy_addr     = bus_address[8:0];
            delay_left    = 1 + ($random(seed) & 3);
            if (bus_write_enable) begin
                check_store(bus_address, bus_ls_type, bus_write_data);
                write_bytes(bus_address[8:0], bus_ls_type, bus_write_data);
            end
        end
    end

    initial begin
        int cycles;
        bit ok;
        seed          = 32'h75f5fdf6;
        reset         = 1'b0;
        bus_read_done  = 1'b0;
        bus_write_done = 1'b0;
        bus_read_data  = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rec_idx = 0;
        for (int a = 0; a < 512; a++) begin
            pats[a] = '0;
            dmem[a] = 8'(a) ^ {7'b0, 1'(a >> 8)};  // mixes in bit 8 as well
        end
        $readmemh("tb/rv64_patterns.txt", pats);
        n_rec = int'(pats[REC_BASE]);

        repeat (4) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        ok = 1'b1;
        check_value("reset pc", 64'(RAM_BASE), 64'(pc), ok);
        check_value("reset read enable", 64'd0, 64'(bus_read_enable), ok);
        check_value("reset write enable", 64'd0, 64'(bus_write_enable), ok);
        report_test("reset", ok);

        cycles = 0;
        while (rec_idx < n_rec && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rec_idx < n_rec) begin
            $display("timed out waiting for store record %0d of %0d", rec_idx + 1, n_rec);
            errors++;
            tests_failed += n_rec - rec_idx;
        end

        // program spins on its last jal while stray stores are still caught
        cycles = 0;
        while (cycles < 20) begin
            @(negedge clk);
            cycles++;
        end

        $display("%0d tests run, %0d failed, %0d problems", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tb/rv64_patterns.txt
// @000 program words, one instruction per entry, loaded at RAM_BASE
// @100 record count, then per store: address size(ls_type) data name(8 ascii bytes)
@000
12300093 00103023 FFB00113 402081B3 00303423 40115213 00403823 03C15213
00403C23 02409213 00126233 02403023 00112233 001133B3 00421213 00726233
02403423 80000437 FFF4049B 02903823 01700593 00B0953B 02A03C23 0045561B
04C03023 4045569B 04D03423 00001717 04E03823 00108463 0E203C23 04103C23
00116463 06303023 008007EF 0E203C23 06F03423 00000897 00C88067 0E203C23
07103823 18000293 00028A03 07403C23 0002CA03 09403023 00029A03 09403423
0002DA03 09403823 0002AA03 09403C23 0002EA03 0B403023 0082BA03 0B403423
0D4000A3 0D401123 0D402223 0D403423 05500013 0C003823 0000006F
@100
1B
000 3 0000000000000123 6164646920202020
008 3 0000000000000128 7375622020202020
010 3 FFFFFFFFFFFFFFFD 7372616920202020
018 3 000000000000000F 73726C6920202020
020 3 0000123000000123 736C6C695F6F7220
028 3 0000000000000010 736C742020202020
030 3 000000007FFFFFFF 6164646977202020
038 3 FFFFFFFF91800000 736C6C7720202020
040 3 0000000009180000 73726C6977202020
048 3 FFFFFFFFF9180000 7372616977202020
050 3 000000000000106C 6175697063202020
058 3 0000000000000123 6265712020202020
060 3 0000000000000128 626C747520202020
068 3 000000000000008C 6A616C2020202020
070 3 0000000000000094 6A616C7220202020
078 3 FFFFFFFFFFFFFF81 6C62202020202020
080 3 0000000000000081 6C62752020202020
088 3 FFFFFFFFFFFF8081 6C68202020202020
090 3 0000000000008081 6C68752020202020
098 3 FFFFFFFF82838081 6C77202020202020
0A0 3 0000000082838081 6C77752020202020
0A8 3 8E8F8C8D8A8B8889 6C64202020202020
0C1 0 0000000000000089 7362202020202020
0C2 1 0000000000008889 7368202020202020
0C4 2 000000008A8B8889 7377202020202020
0C8 3 8E8F8C8D8A8B8889 7364202020202020
0D0 3 0000000000000000 7830202020202020

// File: sources.f
common/rv64_pkg.sv
hw/fetch_unit.sv
hw/instr_decode.sv
hw/reg_file.sv
exec/exec_alu.sv
exec/load_store_unit.sv
hw/rv64_core.sv
tb/tb_rv64_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_rv64_core -f sources.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_rv64_core)
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
